//--- stream_pkg.sv
package stream_pkg;

    // tag nibble sits above the payload in every fifo word
    typedef logic [3:0] tag_t;

    // the three record kinds the acquisition side produces
    localparam tag_t TAG_FILL = 4'd1;
    localparam tag_t TAG_WFM  = 4'd2;
    localparam tag_t TAG_CKSM = 4'd4;

    // payload of one record
    // the same width as one memory data beat
    localparam int PAYLOAD_W = 128;

    // one word at the head of the fwft fifo
    typedef struct packed {
        tag_t                 tag;
        logic [PAYLOAD_W-1:0] payload;
    } stream_rec_t;

    // waveform header burst count
    // counts data beats that follow the header
    localparam int BURST_CNT_W = 23;

    // start address of the fill in units of one burst
    localparam int START_ADDR_LSB = 53;
    localparam int START_ADDR_W   = 23;

    // total bursts of a whole fill
    // fill header, waveform headers and data, checksum
    localparam int TOTAL_W = 24;

    // summary record sent once the checksum is in memory
    // total count rides above the saved fill header payload
    typedef struct packed {
        logic [TOTAL_W-1:0]   total_bursts;
        logic [PAYLOAD_W-1:0] payload;
    } summary_rec_t;

endpackage

//--- mem_pkg.sv
package mem_pkg;

    // address of one burst in the acquisition region
    localparam int BURST_ADDR_W = 23;

    // a burst covers eight column addresses
    localparam int BURST_LSB_W = 3;

    // address as the memory controller wants it
    localparam int MEM_ADDR_W = BURST_ADDR_W + BURST_LSB_W;

    // beats written ahead of their commands
    // 31 at most
    localparam int CREDIT_W = 5;

    // beats or commands left in one segment
    // room for a full burst count plus the header beat
    localparam int SEG_CNT_W = 24;

    // one data beat carries one whole record payload
    localparam int WDF_DATA_W = stream_pkg::PAYLOAD_W;

    // write data fifo beat
    typedef struct packed {
        logic [WDF_DATA_W-1:0] data;
        logic                  last;
    } wdf_beat_t;

endpackage

//--- wr_sequencer.sv
`timescale 1ns/1ns

module wr_sequencer (
    input  logic             clk,
    input  logic             reset,
    input  logic             acq_enabled,
    input  logic             acq_done,
    input  logic             rec_valid,
    input  stream_pkg::tag_t rec_tag,
    input  logic             seg_done,
    input  logic             summary_sent,
    output logic             load_fill,
    output logic             load_wfm,
    output logic             load_single,
    output logic             writing,
    output logic             capture,
    output logic             emit,
    output logic             sync_err,
    output logic             wr_done
);
    import stream_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_TEST_TAG,
        S_SYNC_ERR,
        S_INIT_FILL,
        S_INIT_WFM,
        S_INIT_CKSM,
        S_WRITE,
        S_WRITE_CKSM,
        S_EMIT,
        S_DONE
    } state_t;

    state_t state;
    state_t next_state;
    logic   acq_done_meta;
    logic   acq_done_sync;
    logic   cksm_end;

    // acq_done comes from the acquisition clock domain
    // two flops before the fsm looks at it
    always_ff @(posedge clk) begin
        if (reset) begin
            acq_done_meta <= 1'b0;
            acq_done_sync <= 1'b0;
        end else begin
            acq_done_meta <= acq_done;
            acq_done_sync <= acq_done_meta;
        end
    end

    // dropping acq_enabled parks the fsm in idle
    // this is also the way out of a sync error
    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            // fwft fifo so valid means the head word is usable
            S_IDLE: begin
                if (rec_valid) begin
                    next_state = S_TEST_TAG;
                end
            end
            // any tag outside the three known kinds means lost framing
            S_TEST_TAG: begin
                case (rec_tag)
                    TAG_FILL: next_state = S_INIT_FILL;
                    TAG_WFM:  next_state = S_INIT_WFM;
                    TAG_CKSM: next_state = S_INIT_CKSM;
                    default:  next_state = S_SYNC_ERR;
                endcase
            end
            // held here until reset or acq_enabled low
            S_SYNC_ERR: begin
                next_state = S_SYNC_ERR;
            end
            S_INIT_FILL: begin
                next_state = S_WRITE;
            end
            S_INIT_WFM: begin
                next_state = S_WRITE;
            end
            S_INIT_CKSM: begin
                next_state = S_WRITE_CKSM;
            end
            // header or waveform segment
            // back to idle for the next record
            S_WRITE: begin
                if (seg_done) begin
                    next_state = S_IDLE;
                end
            end
            S_WRITE_CKSM: begin
                if (seg_done) begin
                    next_state = S_EMIT;
                end
            end
            // wait here until the summary is taken
            S_EMIT: begin
                if (summary_sent) begin
                    next_state = S_DONE;
                end
            end
            // no new fill until the acquisition side has finished
            S_DONE: begin
                if (acq_done_sync) begin
                    next_state = S_IDLE;
                end
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    // last beat and command of the checksum both accepted
    assign cksm_end = (state == S_WRITE_CKSM) && seg_done;

    // emit is high on the first cycle of S_EMIT only
    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            emit <= 1'b0;
        end else begin
            emit <= cksm_end;
        end
    end

    // counter loads one cycle after the tag test
    assign load_fill   = (state == S_INIT_FILL);
    assign load_wfm    = (state == S_INIT_WFM);
    assign load_single = (state == S_INIT_CKSM);

    // tracker may move beats and commands
    assign writing = (state == S_WRITE) || (state == S_WRITE_CKSM);

    // fill header still at the fifo head while its tag is tested
    assign capture = (state == S_TEST_TAG) && (rec_tag == TAG_FILL);

    assign sync_err = (state == S_SYNC_ERR);
    assign wr_done  = (state == S_DONE);

    // the tracker loads its counters from exactly one source per record
    a_load_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({load_fill, load_wfm, load_single})
    );

endmodule

//--- burst_tracker.sv
`timescale 1ns/1ns

module burst_tracker (
    input  logic                          clk,
    input  logic                          reset,
    input  stream_pkg::stream_rec_t       rec,
    input  logic                          rec_valid,
    input  logic                          load_fill,
    input  logic                          load_wfm,
    input  logic                          load_single,
    input  logic                          writing,
    input  logic                          cmd_ready,
    input  logic                          wdf_ready,
    output logic                          rec_ready,
    output logic [mem_pkg::MEM_ADDR_W-1:0] cmd_addr,
    output logic                          cmd_valid,
    output mem_pkg::wdf_beat_t            wdf,
    output logic                          wdf_valid,
    output logic                          seg_done
);
    import stream_pkg::*;
    import mem_pkg::*;

    logic [BURST_ADDR_W-1:0] addr_gen;
    logic [SEG_CNT_W-1:0]    addr_cnt;
    logic [SEG_CNT_W-1:0]    burst_cnt;
    logic [SEG_CNT_W-1:0]    wfm_cnt;
    logic [CREDIT_W-1:0]     credit;
    logic                    cmd_accept;
    logic                    wdf_accept;
    logic                    credit_full;

    assign cmd_accept = cmd_valid && cmd_ready;
    assign wdf_accept = wdf_valid && wdf_ready;

    // waveform header plus its data beats
    assign wfm_cnt = SEG_CNT_W'(rec.payload[BURST_CNT_W-1:0]) + SEG_CNT_W'(1);

    // burst address of the next command
    // start comes from the fill header and carries on across the fill
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_gen <= '0;
        end else if (load_fill) begin
            addr_gen <= rec.payload[START_ADDR_LSB +: START_ADDR_W];
        end else if (cmd_accept) begin
            addr_gen <= addr_gen + BURST_ADDR_W'(1);
        end
    end

    // commands still owed for this segment
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_cnt <= '0;
        end else if (load_fill || load_single) begin
            addr_cnt <= SEG_CNT_W'(1);
        end else if (load_wfm) begin
            addr_cnt <= wfm_cnt;
        end else if (cmd_accept) begin
            addr_cnt <= addr_cnt - SEG_CNT_W'(1);
        end
    end

    // data beats still owed for this segment
    always_ff @(posedge clk) begin
        if (reset) begin
            burst_cnt <= '0;
        end else if (load_fill || load_single) begin
            burst_cnt <= SEG_CNT_W'(1);
        end else if (load_wfm) begin
            burst_cnt <= wfm_cnt;
        end else if (wdf_accept) begin
            burst_cnt <= burst_cnt - SEG_CNT_W'(1);
        end
    end

    // beats in memory that still wait for their command
    // both accepted together leaves it unchanged
    always_ff @(posedge clk) begin
        if (reset) begin
            credit <= '0;
        end else if (wdf_accept && !cmd_accept) begin
            credit <= credit + CREDIT_W'(1);
        end else if (cmd_accept && !wdf_accept) begin
            credit <= credit - CREDIT_W'(1);
        end
    end

    // stop sending beats once 31 are ahead
    assign credit_full = &credit;

    // a command only follows data already taken by the controller
    assign cmd_valid = writing && (credit != '0) && (addr_cnt != '0);
    assign cmd_addr  = {addr_gen, {BURST_LSB_W{1'b0}}};

    // each record is a single beat burst
    assign wdf_valid = writing && rec_valid && (burst_cnt != '0) && !credit_full;
    assign wdf.data  = rec.payload;
    assign wdf.last  = 1'b1;

    // pop the fifo head as its beat goes out
    assign rec_ready = wdf_accept;

    assign seg_done = (addr_cnt == '0) && (burst_cnt == '0);

    // idle credit may only move up when a beat arrives
    a_credit_underflow: assert property (
        @(posedge clk) disable iff (reset)
        (credit == '0) && !wdf_accept |=> (credit == '0)
    );

    // controller sees the same command until it takes it
    a_cmd_hold: assert property (
        @(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_addr)
    );

endmodule

//--- fill_summary.sv
`timescale 1ns/1ns

module fill_summary (
    input  logic                     clk,
    input  logic                     reset,
    input  stream_pkg::stream_rec_t  rec,
    input  logic                     capture,
    input  logic                     emit,
    input  logic                     cmd_valid,
    input  logic                     cmd_ready,
    input  logic                     summary_ready,
    output stream_pkg::summary_rec_t summary,
    output logic                     summary_valid,
    output logic                     summary_sent
);
    import stream_pkg::*;

    logic [PAYLOAD_W-1:0] hdr_payload;
    logic [TOTAL_W-1:0]   total_cnt;
    logic                 cmd_accept;

    assign cmd_accept = cmd_valid && cmd_ready;

    // fill header payload without its tag
    always_ff @(posedge clk) begin
        if (capture) begin
            hdr_payload <= rec.payload;
        end
    end

    // starts at one on capture and counts every command of the fill
    // so it ends one above the bursts actually written
    always_ff @(posedge clk) begin
        if (reset) begin
            total_cnt <= '0;
        end else if (capture) begin
            total_cnt <= TOTAL_W'(1);
        end else if (cmd_accept) begin
            total_cnt <= total_cnt + TOTAL_W'(1);
        end
    end

    // snapshot taken on emit and kept until accepted
    always_ff @(posedge clk) begin
        if (emit) begin
            summary <= '{total_bursts: total_cnt, payload: hdr_payload};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            summary_valid <= 1'b0;
        end else if (emit) begin
            summary_valid <= 1'b1;
        end else if (summary_sent) begin
            summary_valid <= 1'b0;
        end
    end

    assign summary_sent = summary_valid && summary_ready;

    // downstream may sample the summary on any stalled cycle
    a_summary_hold: assert property (
        @(posedge clk) disable iff (reset)
        summary_valid && !summary_ready |=> summary_valid && $stable(summary)
    );

endmodule

//--- ddr3_wr_control.sv
`timescale 1ns/1ns

module ddr3_wr_control (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           acq_enabled,
    input  logic                           acq_done,
    input  stream_pkg::stream_rec_t        rec,
    input  logic                           rec_valid,
    output logic                           rec_ready,
    output logic [mem_pkg::MEM_ADDR_W-1:0] cmd_addr,
    output logic                           cmd_valid,
    input  logic                           cmd_ready,
    output mem_pkg::wdf_beat_t             wdf,
    output logic                           wdf_valid,
    input  logic                           wdf_ready,
    output stream_pkg::summary_rec_t       summary,
    output logic                           summary_valid,
    input  logic                           summary_ready,
    output logic                           sync_err,
    output logic                           wr_done
);
    import stream_pkg::*;

    tag_t rec_tag;
    logic load_fill;
    logic load_wfm;
    logic load_single;
    logic writing;
    logic seg_done;
    logic capture;
    logic emit;
    logic summary_sent;

    // fsm only needs the tag of the head record
    assign rec_tag = rec.tag;

    // record classification and fill level control
    wr_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .acq_enabled  (acq_enabled),
        .acq_done     (acq_done),
        .rec_valid    (rec_valid),
        .rec_tag      (rec_tag),
        .seg_done     (seg_done),
        .summary_sent (summary_sent),
        .load_fill    (load_fill),
        .load_wfm     (load_wfm),
        .load_single  (load_single),
        .writing      (writing),
        .capture      (capture),
        .emit         (emit),
        .sync_err     (sync_err),
        .wr_done      (wr_done)
    );

    // memory command and data channels
    burst_tracker u_tracker (
        .clk         (clk),
        .reset       (reset),
        .rec         (rec),
        .rec_valid   (rec_valid),
        .load_fill   (load_fill),
        .load_wfm    (load_wfm),
        .load_single (load_single),
        .writing     (writing),
        .cmd_ready   (cmd_ready),
        .wdf_ready   (wdf_ready),
        .rec_ready   (rec_ready),
        .cmd_addr    (cmd_addr),
        .cmd_valid   (cmd_valid),
        .wdf         (wdf),
        .wdf_valid   (wdf_valid),
        .seg_done    (seg_done)
    );

    // per fill summary record
    fill_summary u_summary (
        .clk           (clk),
        .reset         (reset),
        .rec           (rec),
        .capture       (capture),
        .emit          (emit),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .summary_ready (summary_ready),
        .summary       (summary),
        .summary_valid (summary_valid),
        .summary_sent  (summary_sent)
    );

endmodule

//--- tb_ddr3_wr_control.sv
`timescale 1ns/1ns

module tb_ddr3_wr_control;
    import stream_pkg::*;
    import mem_pkg::*;

    logic                  clk;
    logic                  reset;
    logic                  acq_enabled;
    logic                  acq_done;
    stream_rec_t           rec;
    logic                  rec_valid;
    logic                  rec_ready;
    logic [MEM_ADDR_W-1:0] cmd_addr;
    logic                  cmd_valid;
    logic                  cmd_ready;
    wdf_beat_t             wdf;
    logic                  wdf_valid;
    logic                  wdf_ready;
    summary_rec_t          summary;
    logic                  summary_valid;
    logic                  summary_ready;
    logic                  sync_err;
    logic                  wr_done;

    // modeled fwft fifo contents and what memory and summary should see
    stream_rec_t           stream_q[$];
    logic [PAYLOAD_W-1:0]  beat_q[$];
    logic [MEM_ADDR_W-1:0] cmd_q[$];
    summary_rec_t          sum_q[$];
    int                    wfm_lens[$];

    // handshakes seen at the rising edge
    logic                  rec_pop = 1'b0;
    logic                  beat_acc = 1'b0;
    logic                  cmd_acc = 1'b0;
    logic                  sum_acc = 1'b0;

    // position in the expected streams
    int                    beat_idx = 0;
    int                    cmd_idx = 0;
    int                    sum_idx = 0;
    logic                  have_beat = 1'b0;
    logic                  have_cmd = 1'b0;
    logic                  have_sum = 1'b0;
    logic [PAYLOAD_W-1:0]  exp_beat = '0;
    logic [MEM_ADDR_W-1:0] exp_addr = '0;
    summary_rec_t          exp_summary = '0;
    logic                  bad_sent = 1'b0;
    int unsigned           cmd_odds = 6;
    int unsigned           seed_val;

    ddr3_wr_control DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [PAYLOAD_W-1:0] random_payload();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // one fill into the fifo model
    // abort swaps the checksum for a record with an unknown tag
    task automatic queue_fill(input logic [START_ADDR_W-1:0] start, input bit abort);
        stream_rec_t          r;
        logic [PAYLOAD_W-1:0] hdr;
        int                   n_rec;
        int                   total;
        int                   k;
        int                   n;
        @(posedge clk);
        hdr = random_payload();
        hdr[START_ADDR_LSB +: START_ADDR_W] = start;
        r.tag = TAG_FILL;
        r.payload = hdr;
        stream_q.push_back(r);
        beat_q.push_back(hdr);
        n_rec = 1;
        // fill header, checksum and the summary count itself
        total = 3;
        foreach (wfm_lens[i]) begin
            r.tag = TAG_WFM;
            r.payload = random_payload();
            r.payload[BURST_CNT_W-1:0] = BURST_CNT_W'(wfm_lens[i]);
            stream_q.push_back(r);
            beat_q.push_back(r.payload);
            // data beats are never classified so their tag is free
            for (k = 0; k < wfm_lens[i]; k++) begin
                r.tag = 4'h0;
                r.payload = random_payload();
                stream_q.push_back(r);
                beat_q.push_back(r.payload);
            end
            n_rec += wfm_lens[i] + 1;
            total += wfm_lens[i] + 1;
        end
        if (abort) begin
            r.tag = 4'h3;
            r.payload = random_payload();
            stream_q.push_back(r);
            bad_sent = 1'b1;
        end else begin
            r.tag = TAG_CKSM;
            r.payload = random_payload();
            stream_q.push_back(r);
            beat_q.push_back(r.payload);
            n_rec++;
            sum_q.push_back('{total_bursts: TOTAL_W'(total), payload: hdr});
        end
        // one burst address per record wrapping at the top of the region
        for (n = 0; n < n_rec; n++) begin
            cmd_q.push_back(MEM_ADDR_W'(BURST_ADDR_W'(start + n)) << 3);
        end
    endtask

    // which selects wr_done with 0 and sync_err with 1
    task automatic wait_for_status(input int which, input logic level, input int limit,
                                   input string what);
        int   cycles;
        logic now;
        cycles = 0;
        now = (which == 0) ? wr_done : sync_err;
        while (now !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                report_error({"timeout waiting for ", what});
            end
            now = (which == 0) ? wr_done : sync_err;
        end
    endtask

    task automatic finish_fill();
        wait_for_status(0, 1'b1, 2000, "wr_done to rise");
        // acquisition side still busy for a while
        repeat (8) @(negedge clk);
        acq_done = 1'b1;
        wait_for_status(0, 1'b0, 3, "wr_done to fall after acq_done");
        acq_done = 1'b0;
    endtask

    task automatic check_all_consumed();
        @(posedge clk);
        if (beat_idx != beat_q.size()) begin
            report_error($sformatf("FAILED beat count %h expected %h", beat_idx, beat_q.size()));
        end
        if (cmd_idx != cmd_q.size()) begin
            report_error($sformatf("FAILED cmd count %h expected %h", cmd_idx, cmd_q.size()));
        end
        if (sum_idx != sum_q.size()) begin
            report_error($sformatf("FAILED summary count %h expected %h", sum_idx, sum_q.size()));
        end
    endtask

    always @(posedge clk) begin
        rec_pop  = rec_valid && rec_ready;
        beat_acc = wdf_valid && wdf_ready;
        cmd_acc  = cmd_valid && cmd_ready;
        sum_acc  = summary_valid && summary_ready;
    end

    // advance the models, then drive the next cycle
    always @(negedge clk) begin
        if (rec_pop) begin
            stream_q.delete(0);
        end
        beat_idx += int'(beat_acc);
        cmd_idx += int'(cmd_acc);
        sum_idx += int'(sum_acc);
        have_beat = beat_idx < beat_q.size();
        have_cmd = cmd_idx < cmd_q.size();
        have_sum = sum_idx < sum_q.size();
        if (have_beat) begin
            exp_beat = beat_q[beat_idx];
        end
        if (have_cmd) begin
            exp_addr = cmd_q[cmd_idx];
        end
        if (have_sum) begin
            exp_summary = sum_q[sum_idx];
        end
        wdf_ready     = ($urandom % 8) < 7;
        cmd_ready     = ($urandom % 8) < cmd_odds;
        summary_ready = ($urandom % 2) == 1;
        rec_valid = stream_q.size() != 0;
        if (rec_valid) begin
            rec = stream_q[0];
        end else begin
            rec = '0;
        end
    end

    a_beat_data: assert property (@(posedge clk) disable iff (reset)
        wdf_valid && wdf_ready |-> have_beat && wdf.data == exp_beat)
        else report_error($sformatf("FAILED wdf.data %h expected %h", wdf.data, exp_beat));
    a_beat_last: assert property (@(posedge clk) disable iff (reset) wdf_valid |-> wdf.last)
        else report_error($sformatf("FAILED wdf.last %h expected 1", wdf.last));
    // the fifo head goes exactly with its beat
    a_pop_once: assert property (@(posedge clk) disable iff (reset)
        rec_ready == (wdf_valid && wdf_ready))
        else report_error($sformatf("FAILED rec_ready %h expected %h",
                                    rec_ready, wdf_valid && wdf_ready));
    a_cmd_addr: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && cmd_ready |-> have_cmd && cmd_addr == exp_addr)
        else report_error($sformatf("FAILED cmd_addr %h expected %h", cmd_addr, exp_addr));
    a_cmd_order: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && cmd_ready |-> cmd_idx < beat_idx)
        else report_error("a command was accepted before its data beat");
    a_summary: assert property (@(posedge clk) disable iff (reset)
        summary_valid |-> have_sum && summary == exp_summary)
        else report_error($sformatf("FAILED summary %h expected %h", summary, exp_summary));
    a_summary_hold: assert property (@(posedge clk) disable iff (reset)
        summary_valid && !summary_ready |=> summary_valid && $stable(summary))
        else report_error("summary changed or dropped while stalled");
    a_done_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(wr_done) |-> $past(summary_valid && summary_ready))
        else report_error("wr_done rose without an accepted summary");
    a_done_hold: assert property (@(posedge clk) disable iff (reset)
        wr_done && !acq_done |=> wr_done)
        else report_error("wr_done fell before acq_done was raised");
    a_err_quiet: assert property (@(posedge clk) disable iff (reset)
        sync_err |-> !rec_ready && !wdf_valid && !cmd_valid)
        else report_error("memory traffic while in sync error");
    a_err_sticky: assert property (@(posedge clk) disable iff (reset)
        sync_err && acq_enabled |=> sync_err)
        else report_error("sync_err cleared while acq_enabled was still high");
    a_err_cause: assert property (@(posedge clk) disable iff (reset) sync_err |-> bad_sent)
        else report_error("sync_err raised without an unknown tag");

    initial begin
        reset = 1'b1;
        acq_enabled = 1'b0;
        acq_done = 1'b0;
        rec = '0;
        rec_valid = 1'b0;
        cmd_ready = 1'b0;
        wdf_ready = 1'b0;
        summary_ready = 1'b0;
        seed_val = $urandom(32'h2727);
        repeat (4) @(posedge clk);
        @(negedge clk);
        // bits are rec_ready cmd_valid wdf_valid summary_valid sync_err wr_done
        if (rec_ready || cmd_valid || wdf_valid || summary_valid || sync_err || wr_done) begin
            report_error($sformatf("FAILED outputs after reset %h expected 00",
                                   {rec_ready, cmd_valid, wdf_valid, summary_valid,
                                    sync_err, wr_done}));
        end
        reset = 1'b0;
        acq_enabled = 1'b1;

        // empty waveform in the middle of the fill
        wfm_lens = {3, 0, 5};
        queue_fill(23'h012345, 1'b0);
        finish_fill();

        // slow commands let data run ahead and the address wraps past the top
        cmd_odds = 2;
        wfm_lens = {40, 2};
        queue_fill(23'h7ffff0, 1'b0);
        finish_fill();
        cmd_odds = 6;

        // framing lost after one waveform
        wfm_lens = {2};
        queue_fill(23'h000400, 1'b1);
        wait_for_status(1, 1'b1, 500, "sync_err to rise");
        repeat (16) @(negedge clk);
        check_all_consumed();
        @(negedge clk);
        acq_enabled = 1'b0;
        // fifo flushed while acquisition is off
        @(posedge clk);
        stream_q.delete();
        bad_sent = 1'b0;
        repeat (2) @(negedge clk);
        acq_enabled = 1'b1;

        wfm_lens = {1, 4};
        queue_fill(23'h003000, 1'b0);
        finish_fill();
        check_all_consumed();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- project.f
stream_pkg.sv
mem_pkg.sv
wr_sequencer.sv
burst_tracker.sv
fill_summary.sv
ddr3_wr_control.sv
tb_ddr3_wr_control.sv

//--- Makefile
TOP := tb_ddr3_wr_control

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
